//--- Bender.yml
package:
  name: snp_subsystem

sources:
  - include_dirs:
      - source
    files:
      - source/snp_pkg.sv
      - source/snp_slot_queue.sv
      - source/snp_forwarder.sv
      - source/snp_bank_tags.sv
      - source/snp_ack_arbiter.sv
      - source/snp_subsystem.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/snp_tb.sv

//--- files.f
+incdir+source
source/snp_pkg.sv
source/snp_slot_queue.sv
source/snp_forwarder.sv
source/snp_bank_tags.sv
source/snp_ack_arbiter.sv
source/snp_subsystem.sv
tb/snp_tb.sv

//--- source/snp_ack_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "snp_cfg.svh"

module snp_ack_arbiter (
    input  wire                                        clk,
    input  wire                                        reset,
    input  wire snp_pkg::snp_ack_t [`SNP_NUM_BANKS-1:0] ack,
    input  wire  [`SNP_NUM_BANKS-1:0]                  ack_valid,
    output logic [`SNP_NUM_BANKS-1:0]                  ack_ready,
    output snp_pkg::snp_ack_t                          sel_ack,
    output logic                                       sel_valid,
    input  wire                                        sel_ready
);

    localparam int nb = `SNP_NUM_BANKS;

    snp_pkg::bank_idx_t last_grant, grant;
    logic               found;

    // search starts at the bank after the last grant and wraps around.
    always_comb begin
        int idx;
        grant = last_grant;
        found = 1'b0;
        for (int off = 1; off <= nb; off++) begin
            idx = (int'(last_grant) + off) % nb;
            if (!found && ack_valid[idx]) begin
                grant = snp_pkg::bank_idx_t'(idx);
                found = 1'b1;
            end
        end
    end

    assign sel_valid = found;
    assign sel_ack = ack[grant];

    always_comb begin
        for (int b = 0; b < nb; b++) begin
            ack_ready[b] = sel_ready && found && grant == snp_pkg::bank_idx_t'(b);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_grant <= snp_pkg::bank_idx_t'(nb - 1);
        end else if (found && sel_ready) begin
            last_grant <= grant;
        end
    end

    a_one_ready: assert property (@(posedge clk) disable iff (reset) $onehot0(ack_ready));

endmodule

`default_nettype wire

//--- source/snp_bank_tags.sv
`timescale 1ns/1ps
`default_nettype none
`include "snp_cfg.svh"

module snp_bank_tags #(
    parameter int bank_id = 0
) (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        fill_valid,
    input  wire snp_pkg::line_addr_t   fill_addr,
    input  wire snp_pkg::snp_fwd_t     snp_fwd,
    input  wire                        fwd_valid,
    output logic                       fwd_ready,
    output snp_pkg::snp_ack_t          ack,
    output logic                       ack_valid,
    input  wire                        ack_ready
);

    localparam int bank_w = $clog2(`SNP_NUM_BANKS);
    localparam int set_w = $clog2(`SNP_SETS);
    localparam int utag_w = `SNP_LINE_ADDR_W - bank_w - set_w;

    logic [`SNP_SETS-1:0] line_valid;
    logic [utag_w-1:0]    line_tag [`SNP_SETS];
    logic [set_w-1:0]     fill_set, snp_set;
    logic [utag_w-1:0]    fill_utag, snp_utag;
    logic                 fill_own, snp_own, snp_hit, accept;

    assign fill_own = fill_addr[bank_w-1:0] == snp_pkg::bank_idx_t'(bank_id);
    assign fill_set = fill_addr[bank_w +: set_w];
    assign fill_utag = fill_addr[`SNP_LINE_ADDR_W-1 -: utag_w];

    assign snp_own = snp_fwd.addr[bank_w-1:0] == snp_pkg::bank_idx_t'(bank_id);
    assign snp_set = snp_fwd.addr[bank_w +: set_w];
    assign snp_utag = snp_fwd.addr[`SNP_LINE_ADDR_W-1 -: utag_w];

    // snoops for lines owned by another bank still get an ack, with hit low.
    assign snp_hit = snp_own && line_valid[snp_set] && line_tag[snp_set] == snp_utag;

    assign fwd_ready = !ack_valid;
    assign accept = fwd_valid && fwd_ready;

    // the invalidate is ordered after the fill, so it wins on a shared set.
    always_ff @(posedge clk) begin
        if (reset) begin
            line_valid <= '0;
        end else begin
            if (fill_valid && fill_own) begin
                line_valid[fill_set] <= 1'b1;
            end
            if (accept && snp_hit) begin
                line_valid[snp_set] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_valid && fill_own) begin
            line_tag[fill_set] <= fill_utag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_valid <= 1'b0;
        end else if (accept) begin
            ack_valid <= 1'b1;
        end else if (ack_ready) begin
            ack_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ack <= '{slot: snp_fwd.slot, hit: snp_hit};
        end
    end

    // the forwarder only broadcasts when every bank is ready.
    a_fwd_only_when_ready: assert property (
        @(posedge clk) disable iff (reset) fwd_valid |-> fwd_ready
    );

endmodule

`default_nettype wire

//--- source/snp_cfg.svh
`ifndef SNP_CFG_SVH
`define SNP_CFG_SVH

// number of cache banks that every snoop is broadcast to.
`define SNP_NUM_BANKS 4

// depth of the outstanding-snoop queue.
`define SNP_SLOTS 4

// width of a cache line address.
// The low bits pick the bank and the bits above pick the set.
`define SNP_LINE_ADDR_W 26

// width of the requester's snoop tag.
`define SNP_TAG_W 8

// sets held by each direct-mapped bank.
`define SNP_SETS 8

`endif

//--- source/snp_forwarder.sv
`timescale 1ns/1ps
`default_nettype none
`include "snp_cfg.svh"

module snp_forwarder (
    input  wire                        clk,
    input  wire                        reset,
    input  wire snp_pkg::snp_req_t     snp_req,
    input  wire                        snp_req_valid,
    output logic                       snp_req_ready,
    output snp_pkg::snp_rsp_t          snp_rsp,
    output logic                       snp_rsp_valid,
    input  wire                        snp_rsp_ready,
    output snp_pkg::snp_fwd_t          snp_fwd,
    output logic [`SNP_NUM_BANKS-1:0]  fwd_valid,
    input  wire  [`SNP_NUM_BANKS-1:0]  fwd_ready,
    input  wire snp_pkg::snp_ack_t     sel_ack,
    input  wire                        sel_valid,
    output logic                       sel_ready
);

    localparam int cnt_w = $clog2(`SNP_NUM_BANKS + 1);

    logic [cnt_w-1:0]      pending [`SNP_SLOTS];
    logic [`SNP_SLOTS-1:0] hit_flags;
    snp_pkg::slot_t        alloc_slot;
    snp_pkg::snp_req_t     stored_req;
    logic                  full, all_ready, push, ack_taken, last_ack, pop;

    // every bank takes the snoop in the same cycle or none does.
    assign all_ready = &fwd_ready;
    assign push = snp_req_valid && !full && all_ready;
    assign snp_req_ready = !full && all_ready;
    assign fwd_valid = {`SNP_NUM_BANKS{push}};
    assign snp_fwd = '{addr: snp_req.addr, slot: alloc_slot};

    // acks are only consumed when a response could leave in the same cycle.
    assign sel_ready = snp_rsp_ready;
    assign ack_taken = sel_valid && sel_ready;
    assign last_ack = pending[sel_ack.slot] == cnt_w'(1);
    assign pop = ack_taken && last_ack;

    assign snp_rsp_valid = sel_valid && last_ack;
    assign snp_rsp = '{
        addr: stored_req.addr,
        tag:  stored_req.tag,
        hit:  hit_flags[sel_ack.slot] | sel_ack.hit
    };

    snp_slot_queue slot_queue_i (
        .clk        (clk),
        .reset      (reset),
        .push       (push),
        .push_data  (snp_req),
        .alloc_slot (alloc_slot),
        .full       (full),
        .pop        (pop),
        .pop_slot   (sel_ack.slot),
        .read_slot  (sel_ack.slot),
        .read_data  (stored_req)
    );

    // a pushed slot is never the acked one, since acks name occupied slots.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < `SNP_SLOTS; s++) begin
                pending[s] <= '0;
            end
            hit_flags <= '0;
        end else begin
            if (push) begin
                pending[alloc_slot] <= cnt_w'(`SNP_NUM_BANKS);
                hit_flags[alloc_slot] <= 1'b0;
            end
            if (ack_taken) begin
                pending[sel_ack.slot] <= pending[sel_ack.slot] - cnt_w'(1);
                hit_flags[sel_ack.slot] <= hit_flags[sel_ack.slot] | sel_ack.hit;
            end
        end
    end

    a_ack_has_pending: assert property (
        @(posedge clk) disable iff (reset) ack_taken |-> pending[sel_ack.slot] != '0
    );

endmodule

`default_nettype wire

//--- source/snp_pkg.sv
`default_nettype none
`include "snp_cfg.svh"

package snp_pkg;

    typedef logic [`SNP_LINE_ADDR_W-1:0] line_addr_t;
    typedef logic [`SNP_TAG_W-1:0] req_tag_t;
    typedef logic [$clog2(`SNP_SLOTS)-1:0] slot_t;
    typedef logic [$clog2(`SNP_NUM_BANKS)-1:0] bank_idx_t;

    // a snoop as it arrives from the requester.
    typedef struct packed {
        line_addr_t addr;
        req_tag_t   tag;
    } snp_req_t;

    // hit is the OR of the hits of all banks.
    typedef struct packed {
        line_addr_t addr;
        req_tag_t   tag;
        logic       hit;
    } snp_rsp_t;

    // the slot travels with the snoop so that acks can find their entry.
    typedef struct packed {
        line_addr_t addr;
        slot_t      slot;
    } snp_fwd_t;

    typedef struct packed {
        slot_t slot;
        logic  hit;
    } snp_ack_t;

endpackage

`default_nettype wire

//--- source/snp_slot_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "snp_cfg.svh"

module snp_slot_queue (
    input  wire                clk,
    input  wire                reset,
    input  wire                push,
    input  wire snp_pkg::snp_req_t push_data,
    output snp_pkg::slot_t     alloc_slot,
    output logic               full,
    input  wire                pop,
    input  wire snp_pkg::slot_t pop_slot,
    input  wire snp_pkg::slot_t read_slot,
    output snp_pkg::snp_req_t  read_data
);

    logic [`SNP_SLOTS-1:0] occupied;
    snp_pkg::snp_req_t     entries [`SNP_SLOTS];

    // lowest free slot wins, so the search runs from the top down.
    always_comb begin
        alloc_slot = '0;
        for (int s = `SNP_SLOTS - 1; s >= 0; s--) begin
            if (!occupied[s]) begin
                alloc_slot = snp_pkg::slot_t'(s);
            end
        end
    end

    assign full = &occupied;
    assign read_data = entries[read_slot];

    always_ff @(posedge clk) begin
        if (reset) begin
            occupied <= '0;
        end else begin
            if (push) begin
                occupied[alloc_slot] <= 1'b1;
            end
            if (pop) begin
                occupied[pop_slot] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[alloc_slot] <= push_data;
        end
    end

    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (reset) push |-> !full
    );

    a_pop_occupied: assert property (
        @(posedge clk) disable iff (reset) pop |-> occupied[pop_slot]
    );

endmodule

`default_nettype wire

//--- source/snp_subsystem.sv
`timescale 1ns/1ps
`default_nettype none
`include "snp_cfg.svh"

module snp_subsystem (
    input  wire                      clk,
    input  wire                      reset,
    input  wire snp_pkg::snp_req_t   snp_req,
    input  wire                      snp_req_valid,
    output logic                     snp_req_ready,
    output snp_pkg::snp_rsp_t        snp_rsp,
    output logic                     snp_rsp_valid,
    input  wire                      snp_rsp_ready,
    input  wire                      fill_valid,
    input  wire snp_pkg::line_addr_t fill_addr
);

    snp_pkg::snp_fwd_t                      snp_fwd;
    logic [`SNP_NUM_BANKS-1:0]              fwd_valid, fwd_ready;
    snp_pkg::snp_ack_t [`SNP_NUM_BANKS-1:0] ack;
    logic [`SNP_NUM_BANKS-1:0]              ack_valid, ack_ready;
    snp_pkg::snp_ack_t                      sel_ack;
    logic                                   sel_valid, sel_ready;

    snp_forwarder forwarder_i (
        .clk           (clk),
        .reset         (reset),
        .snp_req       (snp_req),
        .snp_req_valid (snp_req_valid),
        .snp_req_ready (snp_req_ready),
        .snp_rsp       (snp_rsp),
        .snp_rsp_valid (snp_rsp_valid),
        .snp_rsp_ready (snp_rsp_ready),
        .snp_fwd       (snp_fwd),
        .fwd_valid     (fwd_valid),
        .fwd_ready     (fwd_ready),
        .sel_ack       (sel_ack),
        .sel_valid     (sel_valid),
        .sel_ready     (sel_ready)
    );

    for (genvar b = 0; b < `SNP_NUM_BANKS; b++) begin : g_bank
        snp_bank_tags #(
            .bank_id (b)
        ) bank_i (
            .clk        (clk),
            .reset      (reset),
            .fill_valid (fill_valid),
            .fill_addr  (fill_addr),
            .snp_fwd    (snp_fwd),
            .fwd_valid  (fwd_valid[b]),
            .fwd_ready  (fwd_ready[b]),
            .ack        (ack[b]),
            .ack_valid  (ack_valid[b]),
            .ack_ready  (ack_ready[b])
        );
    end

    snp_ack_arbiter arbiter_i (
        .clk       (clk),
        .reset     (reset),
        .ack       (ack),
        .ack_valid (ack_valid),
        .ack_ready (ack_ready),
        .sel_ack   (sel_ack),
        .sel_valid (sel_valid),
        .sel_ready (sel_ready)
    );

endmodule

`default_nettype wire

//--- tb/snp_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "snp_cfg.svh"

module snp_tb;

    localparam int bank_w = $clog2(`SNP_NUM_BANKS);
    localparam int set_w = $clog2(`SNP_SETS);
    localparam int idx_w = bank_w + set_w;

    logic                clk, reset;
    snp_pkg::snp_req_t   snp_req;
    logic                snp_req_valid, snp_req_ready;
    snp_pkg::snp_rsp_t   snp_rsp;
    logic                snp_rsp_valid, snp_rsp_ready;
    logic                fill_valid;
    snp_pkg::line_addr_t fill_addr;

    // model of the banks, keyed by bank and set bits and holding the installed address.
    snp_pkg::line_addr_t lines [int];
    snp_pkg::snp_rsp_t   expected [snp_pkg::req_tag_t];
    snp_pkg::req_tag_t   next_tag = '0;
    int seed = 32'h67ce;
    int errors = 0, checks = 0, test_base = 0, outstanding = 0, stretch = 0;
    bit stall_mode = 1'b0;

    snp_subsystem dut_i (
        .clk           (clk),
        .reset         (reset),
        .snp_req       (snp_req),
        .snp_req_valid (snp_req_valid),
        .snp_req_ready (snp_req_ready),
        .snp_rsp       (snp_rsp),
        .snp_rsp_valid (snp_rsp_valid),
        .snp_rsp_ready (snp_rsp_ready),
        .fill_valid    (fill_valid),
        .fill_addr     (fill_addr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_rsp(input string name, input snp_pkg::snp_rsp_t exp,
                             input snp_pkg::snp_rsp_t act);
        checks++;
        if (exp.addr !== act.addr || exp.tag !== act.tag) begin
            $display("FAIL t=%0t %s expected addr %h tag %h got addr %h tag %h",
                     $time, name, exp.addr, exp.tag, act.addr, act.tag);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    function automatic snp_pkg::line_addr_t rand_addr();
        return snp_pkg::line_addr_t'($random(seed));
    endfunction

    task automatic fill_line(input snp_pkg::line_addr_t addr);
        @(posedge clk);
        fill_valid <= 1'b1;
        fill_addr <= addr;
        lines[int'(addr[idx_w-1:0])] = addr;
        @(posedge clk);
        fill_valid <= 1'b0;
    endtask

    // the expected hit is taken from the model in request order, then the line is dropped.
    task automatic send_snoop(input snp_pkg::line_addr_t addr);
        snp_pkg::snp_rsp_t want;
        snp_pkg::req_tag_t tag;
        int key;
        int waited;
        key = int'(addr[idx_w-1:0]);
        tag = next_tag;
        next_tag++;
        want = '{addr: addr, tag: tag, hit: 1'b0};
        if (lines.exists(key)) begin
            if (lines[key] == addr) begin
                want.hit = 1'b1;
                lines.delete(key);
            end
        end
        expected[tag] = want;
        @(posedge clk);
        snp_req <= '{addr: addr, tag: tag};
        snp_req_valid <= 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!snp_req_ready && waited < 200);
        if (!snp_req_ready) begin
            $display("timeout: snoop with tag %h was never accepted", tag);
            errors++;
            expected.delete(tag);
        end
        @(posedge clk);
        snp_req_valid <= 1'b0;
    endtask

    task automatic wait_drain(input int limit);
        int waited;
        waited = 0;
        while (expected.num() != 0 && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        if (expected.num() != 0) begin
            foreach (expected[t]) begin
                $display("timeout: no response for tag %h addr %h", t, expected[t].addr);
            end
            errors += expected.num();
            expected.delete();
        end
    endtask

    task automatic finish_test(input string name);
        $display("[%0t] %s finished, %0d errors", $time, name, errors - test_base);
        test_base = errors;
    endtask

    // handshakes are observed on the falling edge, where every signal is settled.
    always @(negedge clk) begin
        snp_pkg::snp_rsp_t want;
        if (!reset) begin
            if (outstanding > 0 && snp_req_ready) begin
                $display("snp_req_ready high with %0d snoops outstanding", outstanding);
                errors++;
            end
            if (snp_req_valid && snp_req_ready) begin
                outstanding++;
            end
            if (snp_rsp_valid && snp_rsp_ready) begin
                outstanding--;
                if (!expected.exists(snp_rsp.tag)) begin
                    $display("response with unknown or repeated tag %h", snp_rsp.tag);
                    errors++;
                end else begin
                    want = expected[snp_rsp.tag];
                    check_rsp("snp_rsp", want, snp_rsp);
                    check_flag("snp_rsp.hit", want.hit, snp_rsp.hit);
                    expected.delete(snp_rsp.tag);
                end
            end
        end
    end

    // back-pressure toggles after a random number of cycles.
    always @(posedge clk) begin
        if (!stall_mode) begin
            snp_rsp_ready <= 1'b1;
        end else if (stretch == 0) begin
            snp_rsp_ready <= ~snp_rsp_ready;
        end
    end

    always @(negedge clk) begin
        if (stall_mode) begin
            if (stretch == 0) begin
                stretch = $unsigned($random(seed)) % 12;
            end else begin
                stretch--;
            end
        end
    end

    initial begin
        snp_pkg::line_addr_t picks [8];
        snp_pkg::line_addr_t a, a2;
        reset = 1'b1;
        snp_req = '0;
        snp_req_valid = 1'b0;
        snp_rsp_ready = 1'b1;
        fill_valid = 1'b0;
        fill_addr = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        repeat (8) begin
            @(negedge clk);
            check_flag("snp_rsp_valid", 1'b0, snp_rsp_valid);
            check_flag("snp_req_ready", 1'b1, snp_req_ready);
        end
        send_snoop(rand_addr());
        wait_drain(500);
        finish_test("idle and miss");

        for (int i = 0; i < 6; i++) begin
            picks[i] = rand_addr();
            fill_line(picks[i]);
        end
        for (int i = 0; i < 6; i++) begin
            send_snoop(picks[i]);
        end
        for (int i = 0; i < 6; i++) begin
            send_snoop(picks[i]);
        end
        wait_drain(1000);
        finish_test("fill, hit and invalidate");

        for (int i = 0; i < 3; i++) begin
            picks[i] = rand_addr();
            fill_line(picks[i]);
        end
        for (int i = 0; i < `SNP_SLOTS + 2; i++) begin
            send_snoop(i < 3 ? picks[i] : rand_addr());
        end
        wait_drain(1000);
        finish_test("snoop burst");

        stall_mode <= 1'b1;
        for (int i = 0; i < 4; i++) begin
            picks[i] = rand_addr();
            fill_line(picks[i]);
        end
        for (int i = 0; i < 8; i++) begin
            send_snoop(i % 2 == 0 ? picks[i / 2] : rand_addr());
        end
        wait_drain(4000);
        stall_mode <= 1'b0;
        finish_test("response back-pressure");

        // the second fill shares bank and set with the first, so it evicts it.
        for (int b = 0; b < `SNP_NUM_BANKS; b++) begin
            a = rand_addr();
            a[bank_w-1:0] = bank_w'(b);
            a[bank_w +: set_w] = set_w'($unsigned($random(seed)));
            a2 = a ^ (snp_pkg::line_addr_t'(1) << idx_w);
            fill_line(a);
            fill_line(a2);
            send_snoop(a);
            send_snoop(a2);
        end
        wait_drain(1000);
        finish_test("set conflicts");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
